/* id_macros.svh */
// shared widths, control-bus bit positions, group codes and opcodes for the decode stage
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

`define INST_ADDR_WIDTH 32           // pc width
`define INST_DATA_WIDTH 32           // instruction word
`define REG_ADDR_WIDTH  5            // x0..x31
`define BUS_ADDR_WIDTH  32           // csr number zero-extended to this
`define DECINFO_WIDTH   10
`define CU_BUS_WIDTH    2
`define CU_STALL        0            // hold the stage
`define CU_FLUSH        1            // load a bubble

`define DEC_GRP_ALU     3'd1
`define DEC_GRP_BJU     3'd2
`define DEC_GRP_LSU     3'd3
`define DEC_GRP_CSR     3'd4
`define DEC_GRP_SYS     3'd5         // ecall, ebreak, mret and friends

`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_BRANCH      7'b1100011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_OPIMM       7'b0010011
`define OPC_OP          7'b0110011
`define OPC_SYSTEM      7'b1110011

`endif

/* id_pkg.sv */
// instruction word type shared by the decoders and the testbench, import with id_pkg::*
`include "id_macros.svh"

package id_pkg;

    // standard rv32 field split
    typedef struct packed {
        logic [6:0]                 funct7;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                 opcode;
    } inst_fmt_t;

    // system opcode view, csr number in the top 12 bits
    typedef struct packed {
        logic [11:0]                csr;
        logic [`REG_ADDR_WIDTH-1:0] rs1;     // source reg or zimm
        logic [2:0]                 funct3;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                 opcode;
    } inst_csr_t;

    typedef union packed {
        logic [`INST_DATA_WIDTH-1:0] raw;
        inst_fmt_t                   r;
        inst_csr_t                   c;
    } inst_word_u;

endpackage

/* dec_if.sv */
// control decoder results travelling to the ID/EX register, src drives and snk reads
`timescale 1ns/1ps
`include "id_macros.svh"

interface dec_if;

    logic                        reg_we;
    logic [`REG_ADDR_WIDTH-1:0]  reg_waddr;
    logic [`REG_ADDR_WIDTH-1:0]  reg1_raddr;
    logic [`REG_ADDR_WIDTH-1:0]  reg2_raddr;
    logic                        csr_we;
    logic [`BUS_ADDR_WIDTH-1:0]  csr_waddr;
    logic [`BUS_ADDR_WIDTH-1:0]  csr_raddr;
    logic [`DECINFO_WIDTH-1:0]   dec_info;
    logic                        illegal;
    logic                        jump;      // jal, jalr
    logic                        branch;    // conditional branches

    modport src (output reg_we, reg_waddr, reg1_raddr, reg2_raddr, csr_we, csr_waddr,
                 csr_raddr, dec_info, illegal, jump, branch);
    modport snk (input reg_we, reg_waddr, reg1_raddr, reg2_raddr, csr_we, csr_waddr,
                 csr_raddr, dec_info, illegal, jump, branch);

endinterface

/* idu_ctrl_dec.sv */
// combinational control decoder, turns opcode and funct fields into addresses and enables
`timescale 1ns/1ps
`include "id_macros.svh"

module idu_ctrl_dec import id_pkg::*; (
    input  inst_word_u inst_i,
    dec_if.src         dec_o
);

    logic       reg_we;
    logic       rs1_use;
    logic       rs2_use;
    logic       f3_use;          // funct3 is a real field for this format
    logic       csr_op;
    logic       illegal;
    logic       jump;
    logic       branch;
    logic [2:0] grp;
    logic       f7b5;
    logic       op2_imm;
    logic       op1_pc;
    logic       mem_we;

    always_comb begin
        reg_we  = 1'b0;
        rs1_use = 1'b0;
        rs2_use = 1'b0;
        f3_use  = 1'b0;
        csr_op  = 1'b0;
        illegal = 1'b0;
        jump    = 1'b0;
        branch  = 1'b0;
        grp     = 3'd0;
        f7b5    = 1'b0;
        op2_imm = 1'b0;
        op1_pc  = 1'b0;
        mem_we  = 1'b0;
        case (inst_i.r.opcode)
            `OPC_LUI: begin
                reg_we = 1'b1; grp = `DEC_GRP_ALU; op2_imm = 1'b1;
            end
            `OPC_AUIPC: begin
                reg_we = 1'b1; grp = `DEC_GRP_ALU; op2_imm = 1'b1; op1_pc = 1'b1;
            end
            `OPC_JAL: begin
                reg_we = 1'b1; jump = 1'b1; grp = `DEC_GRP_BJU;
                op2_imm = 1'b1; op1_pc = 1'b1;
            end
            `OPC_JALR: begin
                reg_we = 1'b1; rs1_use = 1'b1; f3_use = 1'b1; jump = 1'b1;
                grp = `DEC_GRP_BJU; op2_imm = 1'b1;
            end
            `OPC_BRANCH: begin
                rs1_use = 1'b1; rs2_use = 1'b1; f3_use = 1'b1; branch = 1'b1;
                grp = `DEC_GRP_BJU; op2_imm = 1'b1; op1_pc = 1'b1;   // target is pc + imm
            end
            `OPC_LOAD: begin
                reg_we = 1'b1; rs1_use = 1'b1; f3_use = 1'b1;
                grp = `DEC_GRP_LSU; op2_imm = 1'b1;
            end
            `OPC_STORE: begin
                rs1_use = 1'b1; rs2_use = 1'b1; f3_use = 1'b1;
                grp = `DEC_GRP_LSU; op2_imm = 1'b1; mem_we = 1'b1;
            end
            `OPC_OPIMM: begin
                reg_we = 1'b1; rs1_use = 1'b1; f3_use = 1'b1;
                grp = `DEC_GRP_ALU; op2_imm = 1'b1;
                f7b5 = (inst_i.r.funct3 == 3'b101) & inst_i.r.funct7[5];   // srai vs srli
            end
            `OPC_OP: begin
                reg_we = 1'b1; rs1_use = 1'b1; rs2_use = 1'b1; f3_use = 1'b1;
                grp = `DEC_GRP_ALU; f7b5 = inst_i.r.funct7[5];
            end
            `OPC_SYSTEM: begin
                f3_use = 1'b1;
                if (inst_i.c.funct3 != 3'b000) begin
                    reg_we  = 1'b1;
                    csr_op  = 1'b1;
                    rs1_use = ~inst_i.c.funct3[2];   // immediate forms carry zimm here
                    grp     = `DEC_GRP_CSR;
                end else begin
                    grp = `DEC_GRP_SYS;
                end
            end
            default: illegal = 1'b1;   // all enables stay low
        endcase
    end

    assign dec_o.reg_we     = reg_we;
    assign dec_o.reg_waddr  = reg_we  ? inst_i.r.rd  : '0;
    assign dec_o.reg1_raddr = rs1_use ? inst_i.r.rs1 : '0;
    assign dec_o.reg2_raddr = rs2_use ? inst_i.r.rs2 : '0;

    // csr number zero-extended onto the bus
    assign dec_o.csr_we    = csr_op;
    assign dec_o.csr_waddr = csr_op ? `BUS_ADDR_WIDTH'(inst_i.c.csr) : '0;
    assign dec_o.csr_raddr = csr_op ? `BUS_ADDR_WIDTH'(inst_i.c.csr) : '0;

    assign dec_o.dec_info = {mem_we, op1_pc, op2_imm, f7b5,
                             (f3_use ? inst_i.r.funct3 : 3'b000), grp};
    assign dec_o.illegal  = illegal;
    assign dec_o.jump     = jump;
    assign dec_o.branch   = branch;

endmodule

/* idu_imm_gen.sv */
// combinational immediate generator, picks the format layout and sign-extends it
`timescale 1ns/1ps
`include "id_macros.svh"

module idu_imm_gen import id_pkg::*; (
    input  inst_word_u  inst_i,
    output logic [31:0] imm_o
);

    logic [`INST_DATA_WIDTH-1:0] w;

    assign w = inst_i.raw;   // bit scatter crosses field borders

    always_comb begin
        case (w[6:0])
            `OPC_LOAD, `OPC_OPIMM, `OPC_JALR: begin
                imm_o = {{20{w[31]}}, w[31:20]};                              // i-type
            end
            `OPC_STORE: begin
                imm_o = {{20{w[31]}}, w[31:25], w[11:7]};                     // s-type
            end
            `OPC_BRANCH: begin
                imm_o = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};  // b-type
            end
            `OPC_LUI, `OPC_AUIPC: begin
                imm_o = {w[31:12], 12'b0};                                    // u-type
            end
            `OPC_JAL: begin
                imm_o = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            `OPC_SYSTEM: begin
                // csr forms carry zimm in rs1, ecall and ebreak get nothing
                if (w[14:12] != 3'b000) begin
                    imm_o = {27'b0, w[19:15]};
                end else begin
                    imm_o = '0;
                end
            end
            default: imm_o = '0;
        endcase
    end

endmodule

/* idu_id_pipe.sv */
// ID/EX pipeline register, held by stall, loaded with a bubble by flush
`timescale 1ns/1ps
`include "id_macros.svh"

module idu_id_pipe (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic [`CU_BUS_WIDTH-1:0]    stall_flag_i,      // from pipeline controller
    dec_if.snk                          dec_i,
    input  logic [31:0]                 dec_imm_i,
    input  logic [`INST_DATA_WIDTH-1:0] inst_i,
    input  logic [`INST_ADDR_WIDTH-1:0] inst_addr_i,
    input  logic                        inst_valid_i,
    input  logic                        is_pred_branch_i,
    output logic [`INST_ADDR_WIDTH-1:0] inst_addr_o,
    output logic                        reg_we_o,
    output logic [`REG_ADDR_WIDTH-1:0]  reg_waddr_o,
    output logic [`REG_ADDR_WIDTH-1:0]  reg1_raddr_o,
    output logic [`REG_ADDR_WIDTH-1:0]  reg2_raddr_o,
    output logic                        csr_we_o,
    output logic [`BUS_ADDR_WIDTH-1:0]  csr_waddr_o,
    output logic [`BUS_ADDR_WIDTH-1:0]  csr_raddr_o,
    output logic [31:0]                 dec_imm_o,
    output logic [`DECINFO_WIDTH-1:0]   dec_info_bus_o,
    output logic                        is_pred_branch_o,
    output logic                        inst_valid_o,
    output logic                        illegal_inst_o,
    output logic [`INST_DATA_WIDTH-1:0] inst_o,
    output logic                        inst_jump_o,
    output logic                        inst_branch_o
);

    logic stall_en;
    logic flush_en;
    logic [$bits(inst_addr_o)+$bits(dec_imm_o)+$bits(inst_o)+96-1:0] stage_q;
    logic [$bits(stage_q)-1:0] stage_d;

    assign stall_en = stall_flag_i[`CU_STALL];
    assign flush_en = stall_flag_i[`CU_FLUSH];   // only acts when not stalled

    // one flat word keeps the whole stage in a single enabled register bank
    assign stage_d = {inst_addr_i, dec_i.reg_we, dec_i.reg_waddr, dec_i.reg1_raddr,
                      dec_i.reg2_raddr, dec_i.csr_we, dec_i.csr_waddr, dec_i.csr_raddr,
                      dec_imm_i, dec_i.dec_info, is_pred_branch_i, inst_valid_i,
                      dec_i.illegal, inst_i, dec_i.jump, dec_i.branch};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stage_q <= '0;
        end else if (!stall_en) begin
            stage_q <= flush_en ? '0 : stage_d;   // flush inserts a bubble
        end
    end

    assign {inst_addr_o, reg_we_o, reg_waddr_o, reg1_raddr_o, reg2_raddr_o, csr_we_o,
            csr_waddr_o, csr_raddr_o, dec_imm_o, dec_info_bus_o, is_pred_branch_o,
            inst_valid_o, illegal_inst_o, inst_o, inst_jump_o, inst_branch_o} = stage_q;

endmodule

/* idu_top.sv */
// decode stage top, both decoders feed the ID/EX register, plain ports for the core
`timescale 1ns/1ps
`include "id_macros.svh"

module idu_top (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic [`INST_DATA_WIDTH-1:0] inst_i,            // fetched word
    input  logic [`INST_ADDR_WIDTH-1:0] inst_addr_i,
    input  logic                        inst_valid_i,
    input  logic                        is_pred_branch_i,  // from branch predictor
    input  logic [`CU_BUS_WIDTH-1:0]    stall_flag_i,
    output logic [`INST_ADDR_WIDTH-1:0] inst_addr_o,
    output logic                        reg_we_o,
    output logic [`REG_ADDR_WIDTH-1:0]  reg_waddr_o,
    output logic [`REG_ADDR_WIDTH-1:0]  reg1_raddr_o,
    output logic [`REG_ADDR_WIDTH-1:0]  reg2_raddr_o,
    output logic                        csr_we_o,
    output logic [`BUS_ADDR_WIDTH-1:0]  csr_waddr_o,
    output logic [`BUS_ADDR_WIDTH-1:0]  csr_raddr_o,
    output logic [31:0]                 dec_imm_o,
    output logic [`DECINFO_WIDTH-1:0]   dec_info_bus_o,
    output logic                        is_pred_branch_o,
    output logic                        inst_valid_o,
    output logic                        illegal_inst_o,
    output logic [`INST_DATA_WIDTH-1:0] inst_o,
    output logic                        inst_jump_o,
    output logic                        inst_branch_o
);

    dec_if       dec_bus ();
    logic [31:0] imm;

    idu_ctrl_dec u_ctrl_dec (.inst_i(inst_i), .dec_o(dec_bus.src));
    idu_imm_gen  u_imm_gen  (.inst_i(inst_i), .imm_o(imm));

    idu_id_pipe u_id_pipe (
        .clk(clk), .rst_n_i(rst_n_i), .stall_flag_i(stall_flag_i),
        .dec_i(dec_bus.snk), .dec_imm_i(imm), .inst_i(inst_i),
        .inst_addr_i(inst_addr_i), .inst_valid_i(inst_valid_i),
        .is_pred_branch_i(is_pred_branch_i),
        .inst_addr_o(inst_addr_o), .reg_we_o(reg_we_o), .reg_waddr_o(reg_waddr_o),
        .reg1_raddr_o(reg1_raddr_o), .reg2_raddr_o(reg2_raddr_o), .csr_we_o(csr_we_o),
        .csr_waddr_o(csr_waddr_o), .csr_raddr_o(csr_raddr_o), .dec_imm_o(dec_imm_o),
        .dec_info_bus_o(dec_info_bus_o), .is_pred_branch_o(is_pred_branch_o),
        .inst_valid_o(inst_valid_o), .illegal_inst_o(illegal_inst_o), .inst_o(inst_o),
        .inst_jump_o(inst_jump_o), .inst_branch_o(inst_branch_o)
    );

endmodule

/* tb_clkgen.sv */
// testbench clock source, free-running clock for the decode stage simulation
`timescale 1ns/1ps

module tb_clkgen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(PERIOD_NS / 2.0) clk_o = ~clk_o;   // 50 % duty

endmodule

/* idu_chk.sv */
// concurrent assertions on the ID/EX register, attached to idu_id_pipe with bind
`timescale 1ns/1ps
`include "id_macros.svh"

module idu_chk (
    input logic                        clk,
    input logic                        rst_n_i,
    input logic [`CU_BUS_WIDTH-1:0]    stall_flag_i,
    input logic                        inst_valid_i,
    input logic [`INST_DATA_WIDTH-1:0] inst_i,
    input logic [`INST_ADDR_WIDTH-1:0] addr_i,
    input logic [31:0]                 imm_i
);

    // a stalled stage keeps its contents
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_flag_i[`CU_STALL] |=> $stable(inst_i) && $stable(addr_i) && $stable(imm_i)
                                    && $stable(inst_valid_i))
        else $error("stage contents changed while stalled");

    // flush without stall leaves a bubble
    a_flush_bubble: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_flag_i[`CU_FLUSH] && !stall_flag_i[`CU_STALL] |=> !inst_valid_i)
        else $error("valid instruction left after flush");

    a_reset_idle: assert property (@(posedge clk) $rose(rst_n_i) |-> !inst_valid_i)
        else $error("valid instruction in first cycle after reset");

endmodule

bind idu_id_pipe idu_chk u_chk (
    .clk(clk), .rst_n_i(rst_n_i), .stall_flag_i(stall_flag_i),
    .inst_valid_i(inst_valid_o), .inst_i(inst_o), .addr_i(inst_addr_o),
    .imm_i(dec_imm_o)
);

/* idu_tb.sv */
// testbench for idu_top, runs a table of instructions and checks every output against a model
`timescale 1ns/1ps
`include "id_macros.svh"

module idu_tb import id_pkg::*; ();

    localparam int N_ROWS         = 24;
    localparam int RST_CYCLES     = 5;
    localparam int TIMEOUT_CYCLES = (N_ROWS * 3 + RST_CYCLES) * 2 + 46;   // 3 cycles/row max

    typedef struct packed {
        logic [`INST_ADDR_WIDTH-1:0] addr;
        logic                        reg_we;
        logic [`REG_ADDR_WIDTH-1:0]  waddr;
        logic [`REG_ADDR_WIDTH-1:0]  raddr1;
        logic [`REG_ADDR_WIDTH-1:0]  raddr2;
        logic                        csr_we;
        logic [`BUS_ADDR_WIDTH-1:0]  csr_waddr;
        logic [`BUS_ADDR_WIDTH-1:0]  csr_raddr;
        logic [31:0]                 imm;
        logic [`DECINFO_WIDTH-1:0]   info;
        logic                        pred;
        logic                        valid;
        logic                        illegal;
        inst_word_u                  inst;
        logic                        jump;
        logic                        branch;
    } stage_t;

    logic                        clk;
    logic                        rst_n_i;
    logic [`INST_DATA_WIDTH-1:0] inst_i;
    logic [`INST_ADDR_WIDTH-1:0] inst_addr_i;
    logic                        inst_valid_i;
    logic                        is_pred_branch_i;
    logic [`CU_BUS_WIDTH-1:0]    stall_flag_i;
    logic [`INST_ADDR_WIDTH-1:0] inst_addr_o;
    logic                        reg_we_o;
    logic [`REG_ADDR_WIDTH-1:0]  reg_waddr_o;
    logic [`REG_ADDR_WIDTH-1:0]  reg1_raddr_o;
    logic [`REG_ADDR_WIDTH-1:0]  reg2_raddr_o;
    logic                        csr_we_o;
    logic [`BUS_ADDR_WIDTH-1:0]  csr_waddr_o;
    logic [`BUS_ADDR_WIDTH-1:0]  csr_raddr_o;
    logic [31:0]                 dec_imm_o;
    logic [`DECINFO_WIDTH-1:0]   dec_info_bus_o;
    logic                        is_pred_branch_o;
    logic                        inst_valid_o;
    logic                        illegal_inst_o;
    logic [`INST_DATA_WIDTH-1:0] inst_o;
    logic                        inst_jump_o;
    logic                        inst_branch_o;

    inst_word_u                  tbl_inst  [N_ROWS];
    logic [`INST_ADDR_WIDTH-1:0] tbl_addr  [N_ROWS];
    logic                        tbl_valid [N_ROWS];
    logic                        tbl_pred  [N_ROWS];
    logic                        tbl_stall [N_ROWS];
    logic                        tbl_flush [N_ROWS];
    stage_t                      expected;
    int                          cycles;

    tb_clkgen #(.PERIOD_NS(4.0)) u_clkgen (.clk_o(clk));

    idu_top dut (
        .clk(clk), .rst_n_i(rst_n_i), .inst_i(inst_i), .inst_addr_i(inst_addr_i),
        .inst_valid_i(inst_valid_i), .is_pred_branch_i(is_pred_branch_i),
        .stall_flag_i(stall_flag_i), .inst_addr_o(inst_addr_o), .reg_we_o(reg_we_o),
        .reg_waddr_o(reg_waddr_o), .reg1_raddr_o(reg1_raddr_o),
        .reg2_raddr_o(reg2_raddr_o), .csr_we_o(csr_we_o), .csr_waddr_o(csr_waddr_o),
        .csr_raddr_o(csr_raddr_o), .dec_imm_o(dec_imm_o), .dec_info_bus_o(dec_info_bus_o),
        .is_pred_branch_o(is_pred_branch_o), .inst_valid_o(inst_valid_o),
        .illegal_inst_o(illegal_inst_o), .inst_o(inst_o), .inst_jump_o(inst_jump_o),
        .inst_branch_o(inst_branch_o)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run aborted");
    endtask

    task automatic check_word(input string name, input logic [31:0] e, input logic [31:0] a);
        if (a !== e) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, e, a);
            abort_run("output mismatch");
        end
    endtask

    task automatic check_reg_addr(input string name, input logic [`REG_ADDR_WIDTH-1:0] e,
                                  input logic [`REG_ADDR_WIDTH-1:0] a);
        if (a !== e) begin
            $display("ERR %0t %s expected %0d actual %0d", $time, name, e, a);
            abort_run("output mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic e, input logic a);
        if (a !== e) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, e, a);
            abort_run("output mismatch");
        end
    endtask

    task automatic check_info(input string name, input logic [`DECINFO_WIDTH-1:0] e,
                              input logic [`DECINFO_WIDTH-1:0] a);
        if (a !== e) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, e, a);
            abort_run("output mismatch");
        end
    endtask

    task automatic check_inst(input string name, input inst_word_u e, input inst_word_u a);
        if (a.raw !== e.raw) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, e.raw, a.raw);
            abort_run("output mismatch");
        end
    endtask

    task automatic check_all(input stage_t e);
        check_word("inst_addr_o", e.addr, inst_addr_o);
        check_flag("reg_we_o", e.reg_we, reg_we_o);
        check_reg_addr("reg_waddr_o", e.waddr, reg_waddr_o);
        check_reg_addr("reg1_raddr_o", e.raddr1, reg1_raddr_o);
        check_reg_addr("reg2_raddr_o", e.raddr2, reg2_raddr_o);
        check_flag("csr_we_o", e.csr_we, csr_we_o);
        check_word("csr_waddr_o", e.csr_waddr, csr_waddr_o);
        check_word("csr_raddr_o", e.csr_raddr, csr_raddr_o);
        check_word("dec_imm_o", e.imm, dec_imm_o);
        check_info("dec_info_bus_o", e.info, dec_info_bus_o);
        check_flag("is_pred_branch_o", e.pred, is_pred_branch_o);
        check_flag("inst_valid_o", e.valid, inst_valid_o);
        check_flag("illegal_inst_o", e.illegal, illegal_inst_o);
        check_inst("inst_o", e.inst, inst_o);
        check_flag("inst_jump_o", e.jump, inst_jump_o);
        check_flag("inst_branch_o", e.branch, inst_branch_o);
    endtask

    function automatic inst_word_u make_word(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [6:0] op);
        inst_word_u w;
        w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: op};
        return w;
    endfunction

    function automatic inst_word_u make_csr(input logic [11:0] csr, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd);
        inst_word_u w;
        w.c = '{csr: csr, rs1: rs1, funct3: f3, rd: rd, opcode: `OPC_SYSTEM};
        return w;
    endfunction

    // expected stage contents for one instruction, from the ISA field rules
    function automatic stage_t predict(input inst_word_u w, input logic [31:0] addr,
                                       input logic valid, input logic pred);
        stage_t     s;
        logic [2:0] grp;
        logic       use1;
        logic       use2;
        logic       f3v;
        logic       f7b5;
        logic       imm2;
        logic       pc1;
        logic       st;
        logic [31:0] b;
        s    = '0;
        grp  = 3'd0;
        use1 = 1'b0;
        use2 = 1'b0;
        f3v  = 1'b1;
        f7b5 = 1'b0;
        imm2 = 1'b1;
        pc1  = 1'b0;
        st   = 1'b0;
        b    = w.raw;
        case (w.r.opcode)
            `OPC_LUI: begin
                s.reg_we = 1'b1;
                grp      = `DEC_GRP_ALU;
                f3v      = 1'b0;
                s.imm    = {b[31:12], 12'h0};
            end
            `OPC_AUIPC: begin
                s.reg_we = 1'b1;
                grp      = `DEC_GRP_ALU;
                f3v      = 1'b0;
                pc1      = 1'b1;
                s.imm    = {b[31:12], 12'h0};
            end
            `OPC_JAL: begin
                s.reg_we = 1'b1;
                s.jump   = 1'b1;
                grp      = `DEC_GRP_BJU;
                f3v      = 1'b0;
                pc1      = 1'b1;
                s.imm    = 32'($signed({b[31], b[19:12], b[20], b[30:21], 1'b0}));
            end
            `OPC_JALR: begin
                s.reg_we = 1'b1;
                s.jump   = 1'b1;
                use1     = 1'b1;
                grp      = `DEC_GRP_BJU;
                s.imm    = 32'($signed(b[31:20]));
            end
            `OPC_BRANCH: begin
                s.branch = 1'b1;
                use1     = 1'b1;
                use2     = 1'b1;
                grp      = `DEC_GRP_BJU;
                pc1      = 1'b1;
                s.imm    = 32'($signed({b[31], b[7], b[30:25], b[11:8], 1'b0}));
            end
            `OPC_LOAD: begin
                s.reg_we = 1'b1;
                use1     = 1'b1;
                grp      = `DEC_GRP_LSU;
                s.imm    = 32'($signed(b[31:20]));
            end
            `OPC_STORE: begin
                use1  = 1'b1;
                use2  = 1'b1;
                grp   = `DEC_GRP_LSU;
                st    = 1'b1;
                s.imm = 32'($signed({b[31:25], b[11:7]}));
            end
            `OPC_OPIMM: begin
                s.reg_we = 1'b1;
                use1     = 1'b1;
                grp      = `DEC_GRP_ALU;
                f7b5     = (w.r.funct3 == 3'b101) && w.r.funct7[5];   // only the shifts
                s.imm    = 32'($signed(b[31:20]));
            end
            `OPC_OP: begin
                s.reg_we = 1'b1;
                use1     = 1'b1;
                use2     = 1'b1;
                grp      = `DEC_GRP_ALU;
                f7b5     = w.r.funct7[5];
                imm2     = 1'b0;
            end
            `OPC_SYSTEM: begin
                imm2 = 1'b0;
                if (w.c.funct3 != 3'b000) begin
                    s.reg_we    = 1'b1;
                    s.csr_we    = 1'b1;
                    use1        = !w.c.funct3[2];   // register forms read rs1
                    grp         = `DEC_GRP_CSR;
                    s.csr_waddr = {20'h0, w.c.csr};
                    s.csr_raddr = {20'h0, w.c.csr};
                    s.imm       = {27'h0, w.c.rs1};
                end else begin
                    grp = `DEC_GRP_SYS;
                end
            end
            default: begin
                s.illegal = 1'b1;
                f3v       = 1'b0;
                imm2      = 1'b0;
            end
        endcase
        s.waddr  = s.reg_we ? w.r.rd : 5'd0;
        s.raddr1 = use1 ? w.r.rs1 : 5'd0;
        s.raddr2 = use2 ? w.r.rs2 : 5'd0;
        s.info   = {st, pc1, imm2, f7b5, (f3v ? w.r.funct3 : 3'b000), grp};
        s.addr   = addr;
        s.valid  = valid;
        s.pred   = pred;
        s.inst   = w;
        return s;
    endfunction

    task automatic build_table();
        tbl_inst[0]  = make_word(7'h5a, 5'd3, 5'd9, 3'b110, 5'd1, `OPC_LUI);
        tbl_inst[1]  = make_word(7'h01, 5'd4, 5'd2, 3'b001, 5'd2, `OPC_AUIPC);
        tbl_inst[2]  = make_word(7'h7c, 5'd17, 5'd21, 3'b011, 5'd1, `OPC_JAL);
        tbl_inst[3]  = make_word(7'h00, 5'd8, 5'd5, 3'b000, 5'd31, `OPC_JALR);
        tbl_inst[4]  = make_word(7'h02, 5'd11, 5'd10, 3'b000, 5'd16, `OPC_BRANCH);
        tbl_inst[5]  = make_word(7'h7f, 5'd12, 5'd13, 3'b001, 5'd29, `OPC_BRANCH);
        tbl_inst[6]  = make_word(7'h40, 5'd4, 5'd6, 3'b010, 5'd7, `OPC_LOAD);
        tbl_inst[7]  = make_word(7'h61, 5'd14, 5'd15, 3'b010, 5'd3, `OPC_STORE);
        tbl_inst[8]  = make_word(7'h7f, 5'd31, 5'd1, 3'b000, 5'd2, `OPC_OPIMM);
        tbl_inst[9]  = make_word(7'h20, 5'd3, 5'd4, 3'b101, 5'd5, `OPC_OPIMM);
        tbl_inst[10] = make_word(7'h20, 5'd18, 5'd19, 3'b000, 5'd20, `OPC_OP);
        tbl_inst[11] = make_word(7'h00, 5'd22, 5'd23, 3'b111, 5'd24, `OPC_OP);
        tbl_inst[12] = make_csr(12'($urandom), 5'd6, 3'b001, 5'd7);    // csrrw
        tbl_inst[13] = make_csr(12'($urandom), 5'd19, 3'b110, 5'd8);   // csrrsi
        tbl_inst[14] = make_csr(12'h000, 5'd0, 3'b000, 5'd0);          // ecall
        tbl_inst[15] = make_word(7'h11, 5'd9, 5'd8, 3'b010, 5'd4, 7'b0001011);
        tbl_inst[16] = make_word(7'h00, 5'd1, 5'd2, 3'b000, 5'd3, `OPC_OP);
        tbl_inst[17] = make_word(7'h00, 5'd4, 5'd5, 3'b000, 5'd6, `OPC_LOAD);
        tbl_inst[18] = make_word(7'h3c, 5'd7, 5'd8, 3'b100, 5'd9, `OPC_OPIMM);
        tbl_inst[19] = make_word(7'h12, 5'd10, 5'd11, 3'b000, 5'd12, `OPC_JAL);
        tbl_inst[20] = make_word(7'h7e, 5'd13, 5'd14, 3'b100, 5'd15, `OPC_LOAD);
        tbl_inst[21] = make_word(7'h7f, 5'd31, 5'd31, 3'b111, 5'd31, 7'h7f);
        tbl_inst[22] = make_word(7'h00, 5'd16, 5'd17, 3'b000, 5'd18, `OPC_STORE);
        tbl_inst[23] = make_csr(12'($urandom), 5'd25, 3'b011, 5'd26);  // csrrc
        for (int i = 0; i < N_ROWS; i++) begin
            tbl_addr[i]  = {$urandom} & 32'hffff_fffc;
            tbl_valid[i] = (i != 20);                // one slot without a valid word
            tbl_pred[i]  = 1'($urandom);
            tbl_stall[i] = (i == 16) || (i == 17);   // plain stall, then stall with flush
            tbl_flush[i] = (i == 17) || (i == 19);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run("timeout: the test table did not finish in time");
        end
    end

    initial begin
        int unused_seed;
        rst_n_i          = 1'b0;
        inst_i           = '0;
        inst_addr_i      = '0;
        inst_valid_i     = 1'b0;
        is_pred_branch_i = 1'b0;
        stall_flag_i     = '0;
        unused_seed      = $urandom(32'h981d_ea37);
        build_table();
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_i  = 1'b1;
        expected = '0;
        check_all(expected);   // everything idle out of reset
        for (int i = 0; i < N_ROWS; i++) begin
            if (i > 0) begin
                @(negedge clk);
                check_all(expected);
            end
            inst_i           = tbl_inst[i].raw;
            inst_addr_i      = tbl_addr[i];
            inst_valid_i     = tbl_valid[i];
            is_pred_branch_i = tbl_pred[i];
            stall_flag_i     = {tbl_flush[i], tbl_stall[i]};
            if (tbl_stall[i]) begin
                expected = expected;   // stall wins over flush
            end else if (tbl_flush[i]) begin
                expected = '0;
            end else begin
                expected = predict(tbl_inst[i], tbl_addr[i], tbl_valid[i], tbl_pred[i]);
            end
        end
        @(negedge clk);
        check_all(expected);
        $display("** PASS **");
        $finish;
    end

endmodule

/* compile.f */
+incdir+.
id_pkg.sv
dec_if.sv
idu_ctrl_dec.sv
idu_imm_gen.sv
idu_id_pipe.sv
idu_top.sv
tb_clkgen.sv
idu_chk.sv
idu_tb.sv

/* run.sh */
#!/bin/sh
# builds the decode stage testbench with Verilator and runs it
verilator --binary --timing --assert -f compile.f --top-module idu_tb -o idu_sim \
    && ./obj_dir/idu_sim \
    || exit 1
